/* rv_decode_top.f */
+incdir+.
rv_isa_pkg.sv
decode_pkg.sv
hs_ctrl.sv
pc_counter.sv
imm_gen.sv
instr_decode.sv
rv_decode_top.sv
tb_rv_decode.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP      := tb_rv_decode
FILELIST := rv_decode_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rv_decode.sv */
`default_nettype none

`include "rv_decode_defs.svh"

module tb_rv_decode;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_TXN      = 208;             // 117 + 46 + 24 + 16 + 5
    localparam int WATCHDOG_NS  = NUM_TXN * (12 + 7) * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 in_req;
    rv_isa_pkg::instr_t   in_instr;
    logic                 out_ack;
    logic                 in_ack;
    logic                 out_req;
    decode_pkg::decoded_t out_pkt;

    logic [15:0]          lfsr_state = 16'd33062;
    decode_pkg::decoded_t exp_q[$];
    int                   delay_q[$];
    decode_pkg::decoded_t exp_pkt;
    decode_pkg::decoded_t held_pkt;
    string                cur_test = "reset";
    int                   txn_idx = 0;
    int                   test_txn = 0;
    int                   err_count = 0;
    int                   err_mark = 0;
    int                   checks_done = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   ack_delay;
    logic                 prev_in_req;
    logic                 prev_in_ack;
    logic                 prev_out_req;

    rv_decode_top uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .out_ack  (out_ack),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_pkt  (out_pkt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
            r          = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic decode_pkg::alu_op_e alu_by_funct3(input logic [2:0] f3,
                                                          input logic alt);
        case (f3)
            3'd0:    return alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'd1:    return decode_pkg::ALU_SLL;
            3'd2:    return decode_pkg::ALU_SLT;
            3'd3:    return decode_pkg::ALU_SLTU;
            3'd4:    return decode_pkg::ALU_XOR;
            3'd5:    return alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'd6:    return decode_pkg::ALU_OR;
            default: return decode_pkg::ALU_AND;
        endcase
    endfunction

    function automatic decode_pkg::decoded_t decode_ref(input rv_isa_pkg::instr_t w,
                                                        input rv_isa_pkg::word_t pc);
        decode_pkg::decoded_t p;
        logic [2:0]           f3;
        logic [6:0]           f7;
        logic                 ok;
        logic                 rel;
        p   = '0;
        f3  = w[14:12];
        f7  = w[31:25];
        ok  = 1'b1;
        rel = 1'b0;
        case (w[6:0])                              // Every kept opcode ends in 11
            rv_isa_pkg::OP_IMM: begin
                p.unit        = decode_pkg::UNIT_ALU;
                p.src2_is_imm = 1'b1;
                p.imm         = {{20{w[31]}}, w[31:20]};
                p.alu_op      = alu_by_funct3(f3, f3 == 3'd5 && f7 == 7'h20);
                ok = !((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20));
            end
            rv_isa_pkg::OP: begin
                p.unit   = decode_pkg::UNIT_ALU;
                p.alu_op = alu_by_funct3(f3, f7 == 7'h20);
                ok       = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
                p.unit = decode_pkg::UNIT_LOAD_IMM;
                p.imm  = {w[31:12], 12'h000};
                rel    = (w[6:0] == rv_isa_pkg::AUIPC);
            end
            rv_isa_pkg::BRANCH: begin
                p.unit        = decode_pkg::UNIT_BRANCH;
                p.imm         = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                p.branch_cond = decode_pkg::branch_cond_e'(f3[2] ? f3 - 3'd2 : f3);  // 4..7 to 2..5
                ok            = (f3[2:1] != 2'b01);
                rel           = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                p.unit = decode_pkg::UNIT_JUMP;
                p.imm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                rel    = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                p.unit = decode_pkg::UNIT_JUMP;
                p.imm  = {{20{w[31]}}, w[31:20]};
                p.jalr = 1'b1;
            end
            rv_isa_pkg::LOAD: begin
                p.unit       = decode_pkg::UNIT_MEM;
                p.imm        = {{20{w[31]}}, w[31:20]};
                p.mem_size   = decode_pkg::mem_size_e'(f3[1:0]);
                p.mem_signed = !(f3 == 3'd4 || f3 == 3'd5);
                ok           = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            rv_isa_pkg::STORE: begin
                p.unit      = decode_pkg::UNIT_MEM;
                p.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
                p.mem_size  = decode_pkg::mem_size_e'(f3[1:0]);
                p.mem_store = 1'b1;
                ok          = (f3 <= 3'd2);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            p = '0;
        end else begin
            p.valid = 1'b1;
            if (rel) begin
                p.pc_rel = pc + p.imm;
            end
        end
        p.rs1 = w[19:15];
        p.rs2 = w[24:20];
        p.rd  = w[11:7];
        p.pc  = pc;
        return p;
    endfunction

    function automatic logic [6:0] kept_opcode(input int idx);
        case (idx)
            0:       return rv_isa_pkg::OP_IMM;
            1:       return rv_isa_pkg::OP;
            2:       return rv_isa_pkg::LUI;
            3:       return rv_isa_pkg::AUIPC;
            4:       return rv_isa_pkg::BRANCH;
            5:       return rv_isa_pkg::JAL;
            6:       return rv_isa_pkg::JALR;
            7:       return rv_isa_pkg::LOAD;
            default: return rv_isa_pkg::STORE;
        endcase
    endfunction

    // Source side of the input handshake
    task automatic send_instr(input rv_isa_pkg::instr_t w);
        rv_isa_pkg::word_t pc_exp;
        pc_exp = rv_isa_pkg::word_t'(`RV_RESET_PC + txn_idx * `RV_PC_STEP);
        exp_q.push_back(decode_ref(w, pc_exp));
        delay_q.push_back(int'(rand_bits(3)));
        @(posedge clk);
        in_req   <= 1'b1;
        in_instr <= w;
        do begin
            @(posedge clk);
        end while (!in_ack);
        in_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (in_ack);
        txn_idx++;
        test_txn++;
    endtask

    // Every opcode x funct3 x funct7 choice that has the wanted legality
    task automatic sweep(input logic want_valid);
        rv_isa_pkg::instr_t   w;
        decode_pkg::decoded_t ref_pkt;
        for (int o = 0; o < 9; o++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int s = 0; s < 2; s++) begin
                    w        = rand_bits(32);
                    w[6:0]   = kept_opcode(o);
                    w[14:12] = 3'(f3);
                    if (w[6:0] == rv_isa_pkg::OP ||
                        (w[6:0] == rv_isa_pkg::OP_IMM && w[13:12] == 2'b01)) begin
                        w[31:25] = (s == 1) ? 7'h20 : 7'h00;
                    end
                    ref_pkt = decode_ref(w, '0);
                    if (ref_pkt.valid == want_valid) begin
                        send_instr(w);
                    end
                end
            end
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0 || out_req || out_ack);
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test();
        int errs;
        wait_drain();
        errs     = err_count - err_mark;
        err_mark = err_count;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d transactions, %0d errors, %s", cur_test, test_txn, errs,
                 (errs == 0) ? "ok" : "FAILED");
        test_txn = 0;
    endtask

    // Sink side of the output handshake
    always begin
        @(posedge clk);
        if (arst_n && out_req && !out_ack) begin
            ack_delay = (delay_q.size() != 0) ? delay_q.pop_front() : 0;
            repeat (ack_delay) @(posedge clk);
            out_ack <= 1'b1;
            do begin
                @(posedge clk);
            end while (out_req);
            out_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            prev_in_req  <= 1'b0;
            prev_in_ack  <= 1'b0;
            prev_out_req <= 1'b0;
        end else begin
            if (in_ack && !prev_in_ack) begin
                assert (prev_in_req) else begin
                    $display("[ERROR] %s: in_ack rose although in_req was low", cur_test);
                    err_count++;
                end
            end
            if (out_req && !prev_out_req) begin
                assert (!in_ack && exp_q.size() != 0) else begin
                    $display("[ERROR] %s: out_req rose too early or with nothing sent",
                             cur_test);
                    err_count++;
                end
                if (exp_q.size() != 0) begin
                    exp_pkt = exp_q.pop_front();
                    checks_done++;
                    assert (out_pkt === exp_pkt) else begin
                        $display("[ERROR] %s: expected %h, actual %h", cur_test, exp_pkt, out_pkt);
                        err_count++;
                    end
                end
                held_pkt <= exp_pkt;
            end else if (out_req || out_ack) begin   // Output transfer still open
                assert (!in_ack) else begin
                    $display("[ERROR] %s: in_ack high during an open output transfer", cur_test);
                    err_count++;
                end
                assert (out_pkt === held_pkt) else begin
                    $display("[ERROR] %s: expected %h, actual %h", cur_test, held_pkt, out_pkt);
                    err_count++;
                end
            end
            prev_in_req  <= in_req;
            prev_in_ack  <= in_ack;
            prev_out_req <= out_req;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rv_isa_pkg::instr_t w;
        arst_n   = 1'b0;
        in_req   = 1'b0;
        in_instr = '0;
        out_ack  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        cur_test = "legal_decode";
        sweep(1'b1);
        end_test();

        cur_test = "illegal_decode";
        sweep(1'b0);
        for (int i = 0; i < 6; i++) begin
            w      = rand_bits(32);
            w[1:0] = 2'(i % 3);                    // Compressed space
            send_instr(w);
        end
        for (int i = 0; i < 8; i++) begin
            w        = rand_bits(32);
            w[6:0]   = rv_isa_pkg::OP;
            w[14:12] = 3'(i);
            w[31:25] = 7'h01;                      // MUL through REMU
            send_instr(w);
        end
        for (int i = 0; i < 2; i++) begin
            w        = rand_bits(32);
            w[6:0]   = rv_isa_pkg::MISC_MEM;
            w[14:12] = 3'(i);                      // FENCE, FENCE.I
            send_instr(w);
        end
        for (int i = 0; i < 3; i++) begin
            w        = rand_bits(32);
            w[6:0]   = (i == 0) ? rv_isa_pkg::OP : rv_isa_pkg::OP_IMM;
            w[14:12] = (i == 0) ? w[14:12] : 3'b101;   // SRLI or SRAI slot
            w[31:25] = 7'h40 | 7'(i);
            send_instr(w);
        end
        end_test();

        cur_test = "address_count";
        for (int i = 0; i < 24; i++) begin
            w = rand_bits(32);
            case (rand_bits(2))
                0: w[6:0] = rv_isa_pkg::AUIPC;
                1: w[6:0] = rv_isa_pkg::JAL;
                default: begin
                    w[6:0]   = rv_isa_pkg::BRANCH;
                    w[14:13] = 2'b00;              // BEQ or BNE
                end
            endcase
            send_instr(w);
        end
        end_test();

        cur_test = "handshake_order";
        for (int i = 0; i < 16; i++) begin
            w        = rand_bits(32);
            w[6:0]   = rv_isa_pkg::LOAD;
            w[14:12] = 3'b010;
            send_instr(w);
        end
        end_test();

        cur_test = "reset_midrun";
        @(posedge clk);
        in_req   <= 1'b1;
        in_instr <= rand_bits(32);
        do begin
            @(posedge clk);
        end while (!in_ack);
        arst_n <= 1'b0;                            // Abort while in_ack is high
        in_req <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        assert (!in_ack && !out_req) else begin
            $display("[ERROR] %s: in_ack or out_req stayed high during reset", cur_test);
            err_count++;
        end
        arst_n <= 1'b1;
        txn_idx = 0;
        test_txn++;
        for (int i = 0; i < 4; i++) begin
            w      = rand_bits(32);
            w[6:0] = rv_isa_pkg::AUIPC;
            send_instr(w);
        end
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d packets checked, %0d errors",
                 tests_run, tests_failed, checks_done, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_decode_top.sv */
`default_nettype none

module rv_decode_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_req,
    input  rv_isa_pkg::instr_t   in_instr,
    input  logic                 out_ack,
    output logic                 in_ack,
    output logic                 out_req,
    output decode_pkg::decoded_t out_pkt
);

    logic                 capture;
    logic                 step;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::imm_set_t imms;

    hs_ctrl u_hs_ctrl (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .out_ack (out_ack),
        .in_ack  (in_ack),
        .out_req (out_req),
        .capture (capture),
        .step    (step)
    );

    pc_counter u_pc_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (step),
        .pc     (pc)
    );

    imm_gen u_imm_gen (
        .instr (in_instr),
        .imms  (imms)
    );

    instr_decode u_instr_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .capture (capture),
        .instr   (in_instr),
        .imms    (imms),
        .pc      (pc),
        .pkt     (out_pkt)
    );

endmodule

`default_nettype wire

/* instr_decode.sv */
`default_nettype none

module instr_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 capture,
    input  rv_isa_pkg::instr_t   instr,
    input  rv_isa_pkg::imm_set_t imms,
    input  rv_isa_pkg::word_t    pc,
    output decode_pkg::decoded_t pkt
);

    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 pc_rel_en;
    decode_pkg::decoded_t pkt_d;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        pkt_d       = '0;
        pkt_d.valid = 1'b1;
        pkt_d.rs1   = instr[19:15];
        pkt_d.rs2   = instr[24:20];
        pkt_d.rd    = instr[11:7];
        pkt_d.pc    = pc;
        pc_rel_en   = 1'b0;

        case (instr[1:0])
            2'b11: begin
                case (rv_isa_pkg::opcode_e'(instr[6:0]))
                    rv_isa_pkg::OP_IMM: begin
                        pkt_d.unit        = decode_pkg::UNIT_ALU;
                        pkt_d.src2_is_imm = 1'b1;
                        pkt_d.imm         = imms.i_imm;
                        case (funct3)
                            3'b000: pkt_d.alu_op = decode_pkg::ALU_ADD;
                            3'b010: pkt_d.alu_op = decode_pkg::ALU_SLT;
                            3'b011: pkt_d.alu_op = decode_pkg::ALU_SLTU;
                            3'b100: pkt_d.alu_op = decode_pkg::ALU_XOR;
                            3'b110: pkt_d.alu_op = decode_pkg::ALU_OR;
                            3'b111: pkt_d.alu_op = decode_pkg::ALU_AND;
                            3'b001: begin
                                if (funct7 == 7'b0000000) begin
                                    pkt_d.alu_op = decode_pkg::ALU_SLL;
                                end else begin
                                    pkt_d.valid = 1'b0;
                                end
                            end
                            default: begin                        // SRLI or SRAI
                                case (funct7)
                                    7'b0000000: pkt_d.alu_op = decode_pkg::ALU_SRL;
                                    7'b0100000: pkt_d.alu_op = decode_pkg::ALU_SRA;
                                    default:    pkt_d.valid = 1'b0;
                                endcase
                            end
                        endcase
                    end

                    rv_isa_pkg::OP: begin
                        pkt_d.unit = decode_pkg::UNIT_ALU;
                        case (funct7)
                            7'b0000000: begin
                                case (funct3)
                                    3'b000:  pkt_d.alu_op = decode_pkg::ALU_ADD;
                                    3'b001:  pkt_d.alu_op = decode_pkg::ALU_SLL;
                                    3'b010:  pkt_d.alu_op = decode_pkg::ALU_SLT;
                                    3'b011:  pkt_d.alu_op = decode_pkg::ALU_SLTU;
                                    3'b100:  pkt_d.alu_op = decode_pkg::ALU_XOR;
                                    3'b101:  pkt_d.alu_op = decode_pkg::ALU_SRL;
                                    3'b110:  pkt_d.alu_op = decode_pkg::ALU_OR;
                                    default: pkt_d.alu_op = decode_pkg::ALU_AND;
                                endcase
                            end
                            7'b0100000: begin
                                case (funct3)
                                    3'b000:  pkt_d.alu_op = decode_pkg::ALU_SUB;
                                    3'b101:  pkt_d.alu_op = decode_pkg::ALU_SRA;
                                    default: pkt_d.valid = 1'b0;
                                endcase
                            end
                            default: pkt_d.valid = 1'b0;          // Includes MUL/DIV
                        endcase
                    end

                    rv_isa_pkg::LUI: begin
                        pkt_d.unit = decode_pkg::UNIT_LOAD_IMM;
                        pkt_d.imm  = imms.u_imm;
                    end

                    rv_isa_pkg::AUIPC: begin
                        pkt_d.unit = decode_pkg::UNIT_LOAD_IMM;
                        pkt_d.imm  = imms.u_imm;
                        pc_rel_en  = 1'b1;
                    end

                    rv_isa_pkg::BRANCH: begin
                        pkt_d.unit = decode_pkg::UNIT_BRANCH;
                        pkt_d.imm  = imms.b_imm;
                        pc_rel_en  = 1'b1;                        // Branch target
                        case (funct3)
                            3'b000:  pkt_d.branch_cond = decode_pkg::BR_BEQ;
                            3'b001:  pkt_d.branch_cond = decode_pkg::BR_BNE;
                            3'b100:  pkt_d.branch_cond = decode_pkg::BR_BLT;
                            3'b101:  pkt_d.branch_cond = decode_pkg::BR_BGE;
                            3'b110:  pkt_d.branch_cond = decode_pkg::BR_BLTU;
                            3'b111:  pkt_d.branch_cond = decode_pkg::BR_BGEU;
                            default: pkt_d.valid = 1'b0;
                        endcase
                    end

                    rv_isa_pkg::JAL: begin
                        pkt_d.unit = decode_pkg::UNIT_JUMP;
                        pkt_d.imm  = imms.j_imm;
                        pc_rel_en  = 1'b1;
                    end

                    rv_isa_pkg::JALR: begin
                        pkt_d.unit = decode_pkg::UNIT_JUMP;
                        pkt_d.imm  = imms.i_imm;
                        pkt_d.jalr = 1'b1;                        // Target from rs1
                    end

                    rv_isa_pkg::LOAD: begin
                        pkt_d.unit = decode_pkg::UNIT_MEM;
                        pkt_d.imm  = imms.i_imm;
                        pkt_d.mem_signed = !funct3[2];            // LBU and LHU zero-extend
                        case (funct3)
                            3'b000, 3'b100: pkt_d.mem_size = decode_pkg::MEM_BYTE;
                            3'b001, 3'b101: pkt_d.mem_size = decode_pkg::MEM_HALF;
                            3'b010:         pkt_d.mem_size = decode_pkg::MEM_WORD;
                            default:        pkt_d.valid = 1'b0;
                        endcase
                    end

                    rv_isa_pkg::STORE: begin
                        pkt_d.unit      = decode_pkg::UNIT_MEM;
                        pkt_d.imm       = imms.s_imm;
                        pkt_d.mem_store = 1'b1;
                        case (funct3)
                            3'b000:  pkt_d.mem_size = decode_pkg::MEM_BYTE;
                            3'b001:  pkt_d.mem_size = decode_pkg::MEM_HALF;
                            3'b010:  pkt_d.mem_size = decode_pkg::MEM_WORD;
                            default: pkt_d.valid = 1'b0;
                        endcase
                    end

                    rv_isa_pkg::MISC_MEM: pkt_d.valid = 1'b0;     // FENCE not handled
                    default:              pkt_d.valid = 1'b0;
                endcase
            end

            default: pkt_d.valid = 1'b0;                          // Compressed or reserved
        endcase

        if (pc_rel_en) begin
            pkt_d.pc_rel = pc + pkt_d.imm;
        end

        // Register indices and pc stay visible on a rejected word
        if (!pkt_d.valid) begin
            pkt_d.unit        = decode_pkg::UNIT_NONE;
            pkt_d.alu_op      = decode_pkg::ALU_ADD;
            pkt_d.src2_is_imm = 1'b0;
            pkt_d.imm         = '0;
            pkt_d.pc_rel      = '0;
            pkt_d.branch_cond = decode_pkg::BR_BEQ;
            pkt_d.jalr        = 1'b0;
            pkt_d.mem_store   = 1'b0;
            pkt_d.mem_size    = decode_pkg::MEM_BYTE;
            pkt_d.mem_signed  = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt <= '0;
        end else if (capture) begin
            pkt <= pkt_d;                                         // Held until next capture
        end
    end

endmodule

`default_nettype wire

/* imm_gen.sv */
`default_nettype none

`include "rv_decode_defs.svh"

module imm_gen (
    input  rv_isa_pkg::instr_t   instr,
    output rv_isa_pkg::imm_set_t imms
);

    // OP-IMM, LOAD, JALR
    assign imms.i_imm = {{(`RV_XLEN - 11){instr[31]}}, instr[30:20]};

    assign imms.s_imm = {{(`RV_XLEN - 11){instr[31]}}, instr[30:25], instr[11:7]};

    // Branch offsets are always even
    assign imms.b_imm = {{(`RV_XLEN - 12){instr[31]}}, instr[7], instr[30:25],
                         instr[11:8], 1'b0};

    assign imms.u_imm = rv_isa_pkg::word_t'({instr[31:12], 12'h000});

    assign imms.j_imm = {{(`RV_XLEN - 20){instr[31]}}, instr[19:12], instr[20],
                         instr[30:21], 1'b0};

endmodule

`default_nettype wire

/* pc_counter.sv */
`default_nettype none

`include "rv_decode_defs.svh"

module pc_counter (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              step,
    output rv_isa_pkg::word_t pc
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= rv_isa_pkg::word_t'(`RV_RESET_PC);
        end else if (step) begin
            pc <= pc + rv_isa_pkg::word_t'(`RV_PC_STEP);   // Next sequential slot
        end
    end

endmodule

`default_nettype wire

/* hs_ctrl.sv */
`default_nettype none

module hs_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic in_req,
    input  logic out_ack,
    output logic in_ack,
    output logic out_req,
    output logic capture,
    output logic step
);

    decode_pkg::hs_state_e state;

    // Word is taken as soon as a request shows up while idle
    assign capture = (state == decode_pkg::IDLE) && in_req;

    // Retire on the falling edge of the sink's acknowledge
    assign step = (state == decode_pkg::RETIRE) && !out_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= decode_pkg::IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            case (state)
                decode_pkg::IDLE: begin
                    if (in_req) begin
                        in_ack <= 1'b1;
                        state  <= decode_pkg::ACK_IN;
                    end
                end

                decode_pkg::ACK_IN: begin
                    if (!in_req) begin                // Source released the word
                        in_ack  <= 1'b0;
                        out_req <= 1'b1;
                        state   <= decode_pkg::OFFER;
                    end
                end

                decode_pkg::OFFER: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= decode_pkg::RETIRE;
                    end
                end

                decode_pkg::RETIRE: begin
                    // Input side stays blocked until the sink lets go
                    if (!out_ack) begin
                        state <= decode_pkg::IDLE;
                    end
                end

                default: begin
                    state   <= decode_pkg::IDLE;
                    in_ack  <= 1'b0;
                    out_req <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* decode_pkg.sv */
`default_nettype none

package decode_pkg;

    typedef enum logic [2:0] {
        UNIT_NONE     = 3'd0,
        UNIT_ALU      = 3'd1,
        UNIT_LOAD_IMM = 3'd2,
        UNIT_BRANCH   = 3'd3,
        UNIT_JUMP     = 3'd4,
        UNIT_MEM      = 3'd5
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_AND  = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLTU = 4'd8,
        ALU_SLT  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5
    } branch_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        IDLE,
        ACK_IN,
        OFFER,
        RETIRE
    } hs_state_e;

    typedef struct packed {
        logic                valid;
        unit_e               unit;
        alu_op_e             alu_op;
        logic                src2_is_imm;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t   imm;
        rv_isa_pkg::word_t   pc_rel;      // pc + imm for AUIPC, JAL, BRANCH
        rv_isa_pkg::word_t   pc;
        branch_cond_e        branch_cond;
        logic                jalr;
        logic                mem_store;
        mem_size_e           mem_size;
        logic                mem_signed;
    } decoded_t;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

`include "rv_decode_defs.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;            // Fixed 32-bit encoding
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    // Major opcodes, low two bits included
    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        BRANCH   = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        MISC_MEM = 7'b0001111                // Not supported here
    } opcode_e;

    typedef struct packed {
        word_t i_imm;
        word_t s_imm;
        word_t b_imm;
        word_t u_imm;
        word_t j_imm;
    } imm_set_t;

endpackage

`default_nettype wire

/* rv_decode_defs.svh */
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Register file index width
`define RV_REG_IDX_W 5

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Byte distance between two instructions
`define RV_PC_STEP 4

`endif
